/* hw/sdram_defs.svh */
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// bus and address widths
`define SDRAM_DQ_W          16   // data bus
`define SDRAM_BA_W          2    // bank select
`define SDRAM_ROW_W         12   // row address
`define SDRAM_COL_W         9    // column address
`define SDRAM_A_W           13   // address pins
`define SDRAM_LEN_W         9    // burst length, up to 256 words

// timing in sys_clk cycles
`define SDRAM_INIT_WAIT     200  // power-up settle, short for sim
`define SDRAM_T_RP          2    // precharge period
`define SDRAM_T_RCD         2    // activate to column cmd
`define SDRAM_T_RFC         7    // auto refresh period
`define SDRAM_CAS_LAT       2    // matches mode register
`define SDRAM_REF_INTERVAL  390  // refresh request spacing

// memory test size
`define TEST_BURST_LEN      64   // words per row burst
`define TEST_NUM_BURSTS     4    // rows per pass
`define ERR_CNT_W           10   // saturating error count

`endif

/* hw/sdram_pkg.sv */
`include "sdram_defs.svh"

package sdram_pkg;

	typedef logic [`SDRAM_DQ_W-1:0] sdram_data_t;   // one data word
	typedef logic [`SDRAM_BA_W+`SDRAM_ROW_W+`SDRAM_COL_W-1:0] sdram_addr_t; // {bank, row, col}
	typedef logic [`SDRAM_A_W-1:0] sdram_a_t;       // address pins
	typedef logic [`SDRAM_BA_W-1:0] sdram_ba_t;     // bank pins
	typedef logic [`SDRAM_LEN_W-1:0] burst_len_t;   // words per burst
	typedef logic [`ERR_CNT_W-1:0] err_cnt_t;       // mismatch count

	// {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		cmd_load_mode = 4'b0000,
		cmd_refresh   = 4'b0001,
		cmd_precharge = 4'b0010,
		cmd_active    = 4'b0011,
		cmd_write     = 4'b0100,
		cmd_read      = 4'b0101,
		cmd_nop       = 4'b0111,
		cmd_inhibit   = 4'b1000  // chip deselected
	} sdram_cmd_t;

	typedef enum logic [2:0] {ini_wait, ini_trp, ini_rfc1, ini_rfc2, ini_mrd, ini_done} init_state_t;

	typedef enum logic [2:0] {st_idle, st_act, st_col, st_twr, st_pre, st_ref} cmd_state_t;

	typedef enum logic [1:0] {ts_wait, ts_write, ts_read, ts_done} test_state_t;

endpackage

/* hw/sdram_init.sv */
`timescale 1ns/10ps
`include "sdram_defs.svh"

module sdram_init (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	output sdram_pkg::sdram_cmd_t init_cmd,
	output sdram_pkg::sdram_a_t   init_a,
	output logic                  init_done
);
	import sdram_pkg::*;

	localparam int MRD_WAIT = 3;              // load mode to done, covers tMRD
	localparam sdram_a_t MODE_VAL = 13'h020;  // bl1, sequential, cl2

	init_state_t state;
	logic [15:0] cnt;                         // cycles spent in current state

	// one-shot command per phase, nop in between
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state     <= ini_wait;
			cnt       <= '0;
			init_cmd  <= cmd_nop;
			init_a    <= '0;
			init_done <= 1'b0;
		end else begin
			cnt      <= cnt + 1'b1;
			init_cmd <= cmd_nop;              // default between phases
			init_a   <= '0;
			case (state)
				ini_wait: if (cnt == 16'(`SDRAM_INIT_WAIT - 1)) begin
					state      <= ini_trp;
					cnt        <= '0;
					init_cmd   <= cmd_precharge;
					init_a[10] <= 1'b1;           // all banks
				end
				ini_trp: if (cnt == 16'(`SDRAM_T_RP - 1)) begin
					state    <= ini_rfc1;
					cnt      <= '0;
					init_cmd <= cmd_refresh;      // first refresh
				end
				ini_rfc1: if (cnt == 16'(`SDRAM_T_RFC - 1)) begin
					state    <= ini_rfc2;
					cnt      <= '0;
					init_cmd <= cmd_refresh;      // second refresh
				end
				ini_rfc2: if (cnt == 16'(`SDRAM_T_RFC - 1)) begin
					state    <= ini_mrd;
					cnt      <= '0;
					init_cmd <= cmd_load_mode;
					init_a   <= MODE_VAL;
				end
				ini_mrd: if (cnt == 16'(MRD_WAIT - 1)) begin
					state     <= ini_done;
					init_done <= 1'b1;            // hand over to main fsm
				end
				ini_done: cnt <= cnt;           // park here until reset
				default:  state <= ini_wait;
			endcase
		end
	end

endmodule

/* hw/sdram_cmd.sv */
`timescale 1ns/10ps
`include "sdram_defs.svh"

module sdram_cmd (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   init_done,
	input  logic                   wr_req,
	input  logic                   rd_req,
	input  sdram_pkg::sdram_addr_t wr_addr,
	input  sdram_pkg::sdram_addr_t rd_addr,
	input  sdram_pkg::burst_len_t  wr_len,
	input  sdram_pkg::burst_len_t  rd_len,
	input  sdram_pkg::sdram_data_t wr_data,
	output logic                   wr_ack,
	output logic                   rd_ack,
	output sdram_pkg::sdram_data_t rd_data,
	output sdram_pkg::sdram_cmd_t  cmd_cmd,
	output sdram_pkg::sdram_a_t    cmd_a,
	output sdram_pkg::sdram_ba_t   cmd_ba,
	output logic                   dq_oe,
	output sdram_pkg::sdram_data_t dq_out,
	input  sdram_pkg::sdram_data_t dq_in
);
	import sdram_pkg::*;

	localparam int RD_LAT = `SDRAM_CAS_LAT + 2;            // pin reg + cas + capture reg
	localparam int REF_W  = $clog2(`SDRAM_REF_INTERVAL);

	cmd_state_t state;
	logic [3:0] tcnt;                       // cycles in current state
	logic       is_wr;                      // burst direction
	sdram_ba_t  ba;
	logic [`SDRAM_ROW_W-1:0] row;
	logic [`SDRAM_COL_W-1:0] col;           // running column
	burst_len_t words;                      // words still to issue
	logic [REF_W-1:0] ref_cnt;
	logic       ref_pend;
	logic       grant_ref, grant_wr, grant_rd;
	logic       rd_issue;
	logic [RD_LAT-1:0] rd_pipe;             // read-valid flags in flight

	// idle arbitration, refresh wins, then write, then read
	assign grant_ref = (state == st_idle) && init_done && ref_pend;
	assign grant_wr  = (state == st_idle) && init_done && !ref_pend && wr_req;
	assign grant_rd  = (state == st_idle) && init_done && !ref_pend && !wr_req && rd_req;

	assign rd_issue = (state == st_col) && !is_wr;
	assign wr_ack   = (state == st_col) && is_wr;   // word taken this cycle
	assign rd_ack   = rd_pipe[RD_LAT-1];
	assign rd_data  = dq_in;                        // already captured in sdram_top
	assign cmd_ba   = ba;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= st_idle;
			tcnt  <= '0;
			is_wr <= 1'b0;
			words <= '0;
			ba    <= '0;
			row   <= '0;
			col   <= '0;
		end else begin
			tcnt <= tcnt + 1'b1;
			case (state)
				st_idle: begin
					tcnt <= '0;
					if (grant_ref) begin
						state <= st_ref;
					end else if (grant_wr) begin
						state <= st_act;
						is_wr <= 1'b1;
						words <= wr_len;
						{ba, row, col} <= wr_addr;
					end else if (grant_rd) begin
						state <= st_act;
						is_wr <= 1'b0;
						words <= rd_len;
						{ba, row, col} <= rd_addr;
					end
				end
				st_act: if (tcnt == 4'(`SDRAM_T_RCD - 1)) begin
					state <= st_col;
				end
				st_col: begin
					tcnt  <= '0;
					words <= words - 1'b1;
					col   <= col + 1'b1;              // one column per cycle
					if (words == burst_len_t'(1))
						state <= is_wr ? st_twr : st_pre;
				end
				st_twr: if (tcnt == 4'd1) begin     // 2-cycle write recovery
					state <= st_pre;
					tcnt  <= '0;
				end
				st_pre: if (tcnt == 4'(`SDRAM_T_RP - 1)) state <= st_idle;
				st_ref: if (tcnt == 4'(`SDRAM_T_RFC - 1)) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	// command decode, sdram_top registers it onto the pins
	always_comb begin
		cmd_cmd = cmd_nop;
		cmd_a   = '0;
		case (state)
			st_act: if (tcnt == '0) begin
				cmd_cmd = cmd_active;
				cmd_a   = sdram_a_t'(row);
			end
			st_col: begin
				cmd_cmd = is_wr ? cmd_write : cmd_read;
				cmd_a   = sdram_a_t'(col);         // a10 low, no auto precharge
			end
			st_pre: if (tcnt == '0) begin
				cmd_cmd   = cmd_precharge;
				cmd_a[10] = 1'b1;                  // all banks
			end
			st_ref: if (tcnt == '0) cmd_cmd = cmd_refresh;
			default: cmd_cmd = cmd_nop;
		endcase
	end

	// refresh timer, runs once init is over
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n || !init_done) begin
			ref_cnt  <= '0;
			ref_pend <= 1'b0;
		end else begin
			ref_cnt <= ref_cnt + 1'b1;
			if (ref_cnt == REF_W'(`SDRAM_REF_INTERVAL - 1)) begin
				ref_cnt  <= '0;
				ref_pend <= 1'b1;
			end else if (grant_ref) begin
				ref_pend <= 1'b0;                  // served by idle
			end
		end
	end

	// data bus drive lines up with the registered write cmd
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			dq_oe   <= 1'b0;
			rd_pipe <= '0;
		end else begin
			dq_oe   <= wr_ack;
			rd_pipe <= {rd_pipe[RD_LAT-2:0], rd_issue};
		end
	end

	always_ff @(posedge sys_clk) begin
		dq_out <= wr_data;
	end

endmodule

/* hw/sdram_top.sv */
`timescale 1ns/10ps

module sdram_top (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  logic                   wr_req,
	input  logic                   rd_req,
	input  sdram_pkg::sdram_addr_t wr_addr,
	input  sdram_pkg::sdram_addr_t rd_addr,
	input  sdram_pkg::burst_len_t  wr_len,
	input  sdram_pkg::burst_len_t  rd_len,
	input  sdram_pkg::sdram_data_t wr_data,
	output logic                   wr_ack,
	output logic                   rd_ack,
	output sdram_pkg::sdram_data_t rd_data,
	output logic                   init_done,
	output logic                   sdram_cke,
	output logic                   sdram_cs_n,
	output logic                   sdram_ras_n,
	output logic                   sdram_cas_n,
	output logic                   sdram_we_n,
	output sdram_pkg::sdram_ba_t   sdram_ba,
	output sdram_pkg::sdram_a_t    sdram_addr,
	output logic [1:0]             sdram_dqm,
	inout  sdram_pkg::sdram_data_t sdram_dq
);
	import sdram_pkg::*;

	sdram_cmd_t  init_cmd, cmd_cmd;
	sdram_cmd_t  pin_cmd;               // registered pin command
	sdram_a_t    init_a, cmd_a;
	sdram_ba_t   cmd_ba;
	logic        dq_oe;
	sdram_data_t dq_out, dq_in;

	sdram_init u_init (.*);            // power-up sequence
	sdram_cmd  u_cmd (.*);             // refresh and bursts

	// init owns the pins until init_done
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			pin_cmd    <= cmd_nop;
			sdram_addr <= '0;
			sdram_ba   <= '0;
		end else begin
			pin_cmd    <= init_done ? cmd_cmd : init_cmd;
			sdram_addr <= init_done ? cmd_a : init_a;
			sdram_ba   <= init_done ? cmd_ba : '0;   // load mode uses bank 0
		end
	end

	always_ff @(posedge sys_clk) begin
		dq_in <= sdram_dq;                 // read data capture
	end

	assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = pin_cmd;
	assign sdram_cke = 1'b1;             // no power-down
	assign sdram_dqm = 2'b00;            // both bytes always enabled
	assign sdram_dq  = dq_oe ? dq_out : 'z;

endmodule

/* hw/sdram_test.sv */
`timescale 1ns/10ps
`include "sdram_defs.svh"

module sdram_test (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  sdram_pkg::sdram_data_t test_seed,
	input  logic                   init_done,
	output logic                   wr_req,
	output sdram_pkg::sdram_addr_t wr_addr,
	output sdram_pkg::burst_len_t  wr_len,
	output sdram_pkg::sdram_data_t wr_data,
	input  logic                   wr_ack,
	output logic                   rd_req,
	output sdram_pkg::sdram_addr_t rd_addr,
	output sdram_pkg::burst_len_t  rd_len,
	input  logic                   rd_ack,
	input  sdram_pkg::sdram_data_t rd_data,
	output logic                   test_done,
	output logic                   test_pass,
	output sdram_pkg::err_cnt_t    err_count
);
	import sdram_pkg::*;

	localparam burst_len_t LAST_WORD = burst_len_t'(`TEST_BURST_LEN - 1);
	localparam logic [`SDRAM_ROW_W-1:0] LAST_ROW = `SDRAM_ROW_W'(`TEST_NUM_BURSTS - 1);

	test_state_t state;
	sdram_data_t seed;                  // latched at end of init
	sdram_data_t word;                  // next write word, later expected read word
	burst_len_t  k;                     // word within burst
	logic [`SDRAM_ROW_W-1:0] row_idx;   // burst number = row
	logic        last_word, last_row;

	assign last_word = (k == LAST_WORD);
	assign last_row  = (row_idx == LAST_ROW);

	// bank 0, row = burst, column 0
	assign wr_addr = {{`SDRAM_BA_W{1'b0}}, row_idx, {`SDRAM_COL_W{1'b0}}};
	assign rd_addr = wr_addr;
	assign wr_len  = burst_len_t'(`TEST_BURST_LEN);
	assign rd_len  = burst_len_t'(`TEST_BURST_LEN);
	assign wr_data = word;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state     <= ts_wait;
			wr_req    <= 1'b0;
			rd_req    <= 1'b0;
			k         <= '0;
			row_idx   <= '0;
			err_count <= '0;
			test_done <= 1'b0;
			test_pass <= 1'b0;
		end else begin
			case (state)
				ts_wait: if (init_done) begin
					state  <= ts_write;
					wr_req <= 1'b1;
				end
				ts_write: if (wr_ack) begin
					wr_req <= 1'b0;                // drop after first ack
					k      <= k + 1'b1;
					if (last_word) begin
						k <= '0;
						if (last_row) begin
							row_idx <= '0;
							rd_req  <= 1'b1;       // start read-back
							state   <= ts_read;
						end else begin
							row_idx <= row_idx + 1'b1;
							wr_req  <= 1'b1;
						end
					end
				end
				ts_read: if (rd_ack) begin
					rd_req <= 1'b0;
					k      <= k + 1'b1;
					if (rd_data != word && err_count != '1)
						err_count <= err_count + 1'b1;  // saturates
					if (last_word) begin
						k <= '0;
						if (last_row) begin
							state <= ts_done;
						end else begin
							row_idx <= row_idx + 1'b1;
							rd_req  <= 1'b1;
						end
					end
				end
				ts_done: begin
					test_done <= 1'b1;
					test_pass <= (err_count == '0);
				end
				default: state <= ts_wait;
			endcase
		end
	end

	// ramp generator, rewound to the seed for the compare pass
	always_ff @(posedge sys_clk) begin
		if (state == ts_wait && init_done) begin
			seed <= test_seed;
			word <= test_seed;
		end else if (state == ts_write && wr_ack) begin
			word <= (last_word && last_row) ? seed : word + 1'b1;
		end else if (state == ts_read && rd_ack) begin
			word <= word + 1'b1;
		end
	end

endmodule

/* hw/sdram_system.sv */
`timescale 1ns/10ps

module sdram_system (
	input  logic                   sys_clk,
	input  logic                   sys_rst_n,
	input  sdram_pkg::sdram_data_t test_seed,
	output logic                   sdram_cke,
	output logic                   sdram_cs_n,
	output logic                   sdram_ras_n,
	output logic                   sdram_cas_n,
	output logic                   sdram_we_n,
	output sdram_pkg::sdram_ba_t   sdram_ba,
	output sdram_pkg::sdram_a_t    sdram_addr,
	output logic [1:0]             sdram_dqm,
	inout  sdram_pkg::sdram_data_t sdram_dq,
	output logic                   test_done,
	output logic                   test_pass,
	output sdram_pkg::err_cnt_t    err_count
);
	import sdram_pkg::*;

	logic        init_done;
	logic        wr_req, rd_req, wr_ack, rd_ack;   // burst handshake
	sdram_addr_t wr_addr, rd_addr;
	burst_len_t  wr_len, rd_len;
	sdram_data_t wr_data, rd_data;

	sdram_test u_test (.*);    // memory test sequencer
	sdram_top  u_top (.*);     // controller and pins

endmodule

/* bench/sdram_model.sv */
`timescale 1ns/10ps
`include "sdram_defs.svh"

module sdram_model (
	input  logic                    clk,
	input  logic                    cke,
	input  logic                    cs_n,
	input  logic                    ras_n,
	input  logic                    cas_n,
	input  logic                    we_n,
	input  sdram_pkg::sdram_ba_t    ba,
	input  sdram_pkg::sdram_a_t     addr,
	input  logic [1:0]              dqm,
	inout  sdram_pkg::sdram_data_t  dq,
	input  logic                    corrupt_en,
	input  logic [`SDRAM_ROW_W-1:0] corrupt_row,
	input  logic [`SDRAM_COL_W-1:0] corrupt_col,
	output int                      viol_count,
	output int                      ref_count,
	output sdram_pkg::sdram_a_t     mode_reg
);
	import sdram_pkg::*;

	localparam int BANKS = 1 << `SDRAM_BA_W;

	sdram_data_t             mem [int unsigned];    // sparse, written words only
	logic [`SDRAM_ROW_W-1:0] open_row [BANKS];      // row held by each bank
	logic [BANKS-1:0]        row_open = '0;
	logic                    mode_set = 1'b0;
	sdram_a_t                mode_q = '0;
	int                      viol_q = 0;
	int                      ref_q = 0;
	logic                    rd_v = 1'b0;           // read in first latency cycle
	sdram_data_t             rd_d;
	logic                    dq_en = 1'b0;
	sdram_data_t             dq_drv;
	sdram_cmd_t              cmd;

	assign cmd        = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
	assign dq         = dq_en ? dq_drv : 'z;        // chip output driver
	assign viol_count = viol_q;
	assign ref_count  = ref_q;
	assign mode_reg   = mode_q;

	// chip samples everything on the rising edge
	always @(posedge clk) begin : decode
		int unsigned key;
		int          v;
		v   = 0;
		key = 32'({ba, open_row[ba], addr[`SDRAM_COL_W-1:0]});
		dq_en  <= rd_v;                                 // second cl2 cycle, data on bus
		dq_drv <= rd_d;
		rd_v   <= 1'b0;
		if (cke && !cs_n) begin
			case (cmd)
				cmd_active: begin
					if (!mode_set) v++;                     // not configured yet
					if (row_open[ba]) v++;                  // bank already open
					row_open[ba] <= 1'b1;
					open_row[ba] <= addr[`SDRAM_ROW_W-1:0];
				end
				cmd_write: begin
					if (!mode_set) v++;
					if (!row_open[ba]) v++;
					if (dqm != 2'b00) v++;                  // masking never used
					if (corrupt_en && open_row[ba] == corrupt_row &&
						addr[`SDRAM_COL_W-1:0] == corrupt_col)
						mem[key] = dq ^ sdram_data_t'(1);   // stuck cell on bit 0
					else
						mem[key] = dq;
				end
				cmd_read: begin
					if (!mode_set) v++;
					if (!row_open[ba]) v++;
					rd_v <= 1'b1;
					rd_d <= mem.exists(key) ? mem[key] : '0;
				end
				cmd_precharge: begin
					if (addr[10])
						row_open <= '0;                     // all banks
					else
						row_open[ba] <= 1'b0;
				end
				cmd_refresh: begin
					if (|row_open) v++;                     // refresh needs all idle
					ref_q <= ref_q + 1;
				end
				cmd_load_mode: begin
					mode_q   <= addr;
					mode_set <= 1'b1;
				end
				default: ;                                  // nop
			endcase
		end
		viol_q <= viol_q + v;
	end

endmodule

/* bench/tb_sdram_system.sv */
`timescale 1ns/10ps
`include "sdram_defs.svh"

module tb_sdram_system;
	import sdram_pkg::*;

	localparam int HALF_PERIOD  = 20;            // 40 ns clock
	localparam int RESET_CYCLES = 16;
	localparam int INIT_CYCLES  = `SDRAM_INIT_WAIT + `SDRAM_T_RP + 2 * `SDRAM_T_RFC + 3;
	localparam int NUM_WORDS    = `TEST_NUM_BURSTS * `TEST_BURST_LEN;
	localparam int REF_LIMIT    = `SDRAM_REF_INTERVAL + `TEST_BURST_LEN + 20;
	localparam int INIT_TIMEOUT = INIT_CYCLES + 100;
	localparam int DONE_TIMEOUT = 20000;         // init_done to test_done
	localparam int BANKS        = 1 << `SDRAM_BA_W;

	logic                    sys_clk;
	logic                    sys_rst_n;
	sdram_data_t             test_seed;
	logic                    sdram_cke;
	logic                    sdram_cs_n;
	logic                    sdram_ras_n;
	logic                    sdram_cas_n;
	logic                    sdram_we_n;
	sdram_ba_t               sdram_ba;
	sdram_a_t                sdram_addr;
	logic [1:0]              sdram_dqm;
	wire [`SDRAM_DQ_W-1:0]   sdram_dq;
	logic                    test_done;
	logic                    test_pass;
	err_cnt_t                err_count;
	logic                    corrupt_en;
	logic [`SDRAM_ROW_W-1:0] corrupt_row;
	logic [`SDRAM_COL_W-1:0] corrupt_col;
	int                      viol_count;
	int                      ref_count;
	sdram_a_t                mode_reg;

	int                      errors;
	int                      writes_seen;          // write cmds this run
	int                      since_ref;            // cycles since last refresh
	int                      word_idx;
	logic                    gap_flagged;
	logic [BANKS-1:0]        open_banks;
	logic [`SDRAM_ROW_W-1:0] act_row [BANKS];      // row opened per bank
	logic [31:0]             lcg_state;
	sdram_data_t             cur_seed;             // seed of the running pass
	sdram_cmd_t              pin_cmd;
	bit                      run_ok;

	assign pin_cmd = sdram_cmd_t'({sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n});

	sdram_system dut0 (.*);

	sdram_model u_mem (
		.clk         (sys_clk),
		.cke         (sdram_cke),
		.cs_n        (sdram_cs_n),
		.ras_n       (sdram_ras_n),
		.cas_n       (sdram_cas_n),
		.we_n        (sdram_we_n),
		.ba          (sdram_ba),
		.addr        (sdram_addr),
		.dqm         (sdram_dqm),
		.dq          (sdram_dq),
		.corrupt_en  (corrupt_en),
		.corrupt_row (corrupt_row),
		.corrupt_col (corrupt_col),
		.viol_count  (viol_count),
		.ref_count   (ref_count),
		.mode_reg    (mode_reg)
	);

	// word k of the ramp, wraps at 2^16
	function automatic sdram_data_t exp_word(input sdram_data_t seed, input int unsigned index);
		return seed + index[`SDRAM_DQ_W-1:0];
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	initial begin
		sys_clk = 1'b0;
		forever #HALF_PERIOD sys_clk = ~sys_clk;
	end

	task automatic apply_reset(input sdram_data_t seed, input logic corrupt);
		@(negedge sys_clk);
		sys_rst_n  = 1'b0;
		test_seed  = seed;                            // sequencer latches it at init end
		cur_seed   = seed;
		corrupt_en = corrupt;
		repeat (RESET_CYCLES) @(negedge sys_clk);
		sys_rst_n = 1'b1;
	endtask

	task automatic wait_init(output bit ok);
		int n;
		n = 0;
		while (dut0.init_done !== 1'b1 && n < INIT_TIMEOUT) begin
			@(negedge sys_clk);
			n++;
		end
		ok = (dut0.init_done === 1'b1);
		if (ok) begin
			check_value("init_done_cycle", INIT_CYCLES, n);
			check_value("mode_burst_len", 0, 32'(mode_reg[2:0]));    // bl1
			check_value("mode_cas_lat", `SDRAM_CAS_LAT, 32'(mode_reg[6:4]));
		end else begin
			note_failure("timeout: init_done did not rise after reset");
		end
	endtask

	task automatic wait_done(output bit ok);
		int n;
		n = 0;
		while (test_done !== 1'b1 && n < DONE_TIMEOUT) begin
			@(negedge sys_clk);
			n++;
		end
		ok = (test_done === 1'b1);
		if (!ok)
			note_failure("timeout: test_done did not rise after init_done");
	endtask

	// pin monitor, sampled mid-cycle
	initial begin
		writes_seen = 0;
		since_ref   = 0;
		gap_flagged = 1'b0;
		open_banks  = '0;
		forever begin
			@(negedge sys_clk);
			if (!sys_rst_n) begin
				writes_seen = 0;
				since_ref   = 0;
				gap_flagged = 1'b0;
				open_banks  = '0;
			end else begin
				if (!dut0.init_done && !sdram_cs_n &&
					!(pin_cmd inside {cmd_nop, cmd_precharge, cmd_refresh, cmd_load_mode}))
					note_failure("unexpected command on the pins during initialization");
				since_ref = dut0.init_done ? since_ref + 1 : 0;
				if (since_ref > REF_LIMIT && !gap_flagged) begin
					gap_flagged = 1'b1;
					note_failure($sformatf("no refresh for %0d cycles", since_ref));
				end
				if (!sdram_cs_n) begin
					case (pin_cmd)
						cmd_active: begin
							open_banks[sdram_ba] = 1'b1;
							act_row[sdram_ba]    = sdram_addr[`SDRAM_ROW_W-1:0];
						end
						cmd_precharge: begin
							if (sdram_addr[10])
								open_banks = '0;              // all banks
							else
								open_banks[sdram_ba] = 1'b0;
						end
						cmd_refresh: begin
							if (|open_banks)
								note_failure("refresh issued while a row is open");
							since_ref = 0;
						end
						cmd_write: begin
							writes_seen++;
							word_idx = int'(act_row[sdram_ba]) * `TEST_BURST_LEN +
								int'(sdram_addr[`SDRAM_COL_W-1:0]);
							check_value("write_bank", 0, 32'(sdram_ba));
							check_value("write_data", 32'(exp_word(cur_seed, word_idx)),
								32'(sdram_dq));
						end
						default: ;
					endcase
				end
			end
		end
	end

	initial begin
		sys_rst_n   = 1'b0;
		test_seed   = '0;
		corrupt_en  = 1'b0;
		corrupt_row = '0;
		corrupt_col = '0;
		errors      = 0;
		cur_seed    = '0;
		lcg_state   = 32'd43;

		// clean pass
		lcg_state = lcg_next(lcg_state);
		apply_reset(lcg_state[31:16], 1'b0);
		wait_init(run_ok);
		if (run_ok)
			wait_done(run_ok);
		if (run_ok) begin
			check_value("clean_test_pass", 1, 32'(test_pass));
			check_value("clean_err_count", 0, 32'(err_count));
			check_value("clean_write_count", NUM_WORDS, writes_seen);
			check_value("clean_violations", 0, viol_count);
			check_value("clean_refresh_seen", 1, 32'(ref_count > 2));   // beyond init's two
		end

		// second pass with one bad cell
		if (run_ok) begin
			lcg_state   = lcg_next(lcg_state);
			corrupt_row = `SDRAM_ROW_W'(lcg_state[15:8] % `TEST_NUM_BURSTS);
			corrupt_col = `SDRAM_COL_W'(lcg_state[7:0] % `TEST_BURST_LEN);
			apply_reset(lcg_state[31:16], 1'b1);
			wait_init(run_ok);
		end
		if (run_ok)
			wait_done(run_ok);
		if (run_ok) begin
			check_value("fault_test_pass", 0, 32'(test_pass));
			check_value("fault_err_count", 1, 32'(err_count));
			check_value("fault_write_count", NUM_WORDS, writes_seen);
			check_value("fault_violations", 0, viol_count);
		end

		$display("errors %0d, model violations %0d, refreshes %0d",
			errors, viol_count, ref_count);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+hw
hw/sdram_pkg.sv
hw/sdram_init.sv
hw/sdram_cmd.sv
hw/sdram_top.sv
hw/sdram_test.sv
hw/sdram_system.sv
bench/sdram_model.sv
bench/tb_sdram_system.sv

/* Makefile */
# Verilator build and run of the SDRAM controller memory test

VERILATOR ?= verilator
TOP       ?= tb_sdram_system
FLAGS     ?= -Wno-fatal
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check for the pass message"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
